//--- logic/mem_pkg.sv
`default_nettype none

package mem_pkg;

    typedef logic [31:0] word_t;   // address or data word
    typedef logic [3:0]  be_t;     // byte lane write enable, bit 0 = lsb
    typedef logic [7:0]  byte_t;   // serial data byte

    // where a load/store ends up
    typedef enum logic [2:0] {
        tgt_base,
        tgt_ext,
        tgt_uart_data,
        tgt_uart_stat,
        tgt_none
    } bus_target_e;

    // position inside a serial frame, tx and rx alike
    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } uart_state_e;

    // address map
    localparam word_t BASE_RAM_BASE  = 32'h8000_0000;
    localparam word_t EXT_RAM_BASE   = 32'h8040_0000;
    localparam word_t UART_DATA_ADDR = 32'hBFD0_03F8;
    localparam word_t UART_STAT_ADDR = 32'hBFD0_03FC;

    // each ram region spans 4 MiB
    localparam int REGION_LSB = 22;

endpackage

`default_nettype wire

//--- logic/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx import mem_pkg::*; #(
    parameter int CLKS_PER_BIT = 16
) (
    input  wire logic  clk_i,
    input  wire logic  locked_i,
    input  wire logic  start_i,
    input  wire byte_t data_i,
    output logic       txd_o,
    output logic       busy_o
);

    localparam int CW = $clog2(CLKS_PER_BIT);

    uart_state_e   state;
    logic [CW-1:0] clk_cnt;
    logic [2:0]    bit_idx;
    byte_t         shift_q;
    logic          bit_done;

    assign bit_done = (clk_cnt == CW'(CLKS_PER_BIT - 1));
    assign busy_o   = (state != st_idle);

    always_ff @(posedge clk_i or negedge locked_i) begin
        if (!locked_i) begin
            state   <= st_idle;
            clk_cnt <= '0;
            bit_idx <= '0;
            shift_q <= '0;
            txd_o   <= 1'b1;   // line idles high
        end else begin
            clk_cnt <= (state == st_idle || bit_done) ? '0 : clk_cnt + 1'b1;
            case (state)
                st_idle: if (start_i) begin
                    shift_q <= data_i;
                    txd_o   <= 1'b0;   // start bit
                    state   <= st_start;
                end
                st_start: if (bit_done) begin
                    txd_o   <= shift_q[0];
                    shift_q <= shift_q >> 1;
                    bit_idx <= '0;
                    state   <= st_data;
                end
                st_data: if (bit_done) begin
                    bit_idx <= bit_idx + 1'b1;
                    if (bit_idx == 3'd7) begin
                        txd_o <= 1'b1;   // stop bit
                        state <= st_stop;
                    end else begin
                        txd_o   <= shift_q[0];   // lsb first
                        shift_q <= shift_q >> 1;
                    end
                end
                default: if (bit_done)
                    state <= st_idle;
            endcase
        end
    end

    a_idle_line_high: assert property (@(posedge clk_i) disable iff (!locked_i)
        (state == st_idle) |-> txd_o);

endmodule

`default_nettype wire

//--- logic/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx import mem_pkg::*; #(
    parameter int CLKS_PER_BIT = 16
) (
    input  wire logic  clk_i,
    input  wire logic  locked_i,
    input  wire logic  rxd_i,
    output logic       valid_o,
    output byte_t      data_o
);

    localparam int CW = $clog2(CLKS_PER_BIT);

    uart_state_e   state;
    logic [CW-1:0] clk_cnt;
    logic [2:0]    bit_idx;
    logic          rxd_meta;
    logic          rxd_sync;
    logic          half_done;
    logic          bit_done;

    assign half_done = (clk_cnt == CW'(CLKS_PER_BIT / 2 - 1));
    assign bit_done  = (clk_cnt == CW'(CLKS_PER_BIT - 1));

    // two flop synchroniser, idle high
    always_ff @(posedge clk_i or negedge locked_i) begin
        if (!locked_i) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
        end else begin
            rxd_meta <= rxd_i;
            rxd_sync <= rxd_meta;
        end
    end

    always_ff @(posedge clk_i or negedge locked_i) begin
        if (!locked_i) begin
            state   <= st_idle;
            clk_cnt <= '0;
            bit_idx <= '0;
            valid_o <= 1'b0;
        end else begin
            valid_o <= 1'b0;
            clk_cnt <= clk_cnt + 1'b1;
            case (state)
                st_idle: begin
                    clk_cnt <= '0;
                    if (!rxd_sync)
                        state <= st_start;   // falling edge of start bit
                end
                st_start: if (half_done) begin
                    clk_cnt <= '0;   // now aligned to bit middles
                    bit_idx <= '0;
                    state   <= rxd_sync ? st_idle : st_data;   // glitch filter
                end
                st_data: if (bit_done) begin
                    clk_cnt <= '0;
                    bit_idx <= bit_idx + 1'b1;
                    if (bit_idx == 3'd7)
                        state <= st_stop;
                end
                default: if (bit_done) begin
                    valid_o <= rxd_sync;   // framing error drops the byte
                    state   <= st_idle;
                end
            endcase
        end
    end

    // payload shift, lsb arrives first
    always_ff @(posedge clk_i) begin
        if (state == st_data && bit_done)
            data_o <= {rxd_sync, data_o[7:1]};
    end

endmodule

`default_nettype wire

//--- logic/serial_port.sv
`timescale 1ns/1ps
`default_nettype none

module serial_port import mem_pkg::*; #(
    parameter int CLKS_PER_BIT = 16
) (
    input  wire logic  clk_i,
    input  wire logic  locked_i,
    input  wire logic  rd_i,
    input  wire logic  wr_i,
    input  wire byte_t wbyte_i,
    input  wire logic  rxd_i,
    output logic       txd_o,
    output logic       tx_ready_o,
    output logic       rx_avail_o,
    output byte_t      rx_byte_o
);

    logic  tx_busy;
    logic  tx_start_q;
    byte_t tx_byte_q;
    logic  rx_valid;
    byte_t rx_data;

    // a start already queued counts as busy
    assign tx_ready_o = !tx_busy && !tx_start_q;

    always_ff @(posedge clk_i or negedge locked_i) begin
        if (!locked_i) begin
            tx_start_q <= 1'b0;
            rx_avail_o <= 1'b0;
        end else begin
            tx_start_q <= wr_i && tx_ready_o;   // writes while busy are dropped
            if (rx_valid)
                rx_avail_o <= 1'b1;   // new byte beats a read
            else if (rd_i)
                rx_avail_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_i && tx_ready_o)
            tx_byte_q <= wbyte_i;
        if (rx_valid)
            rx_byte_o <= rx_data;   // overwrite, even if unread
    end

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx (
        .clk_i    (clk_i),
        .locked_i (locked_i),
        .start_i  (tx_start_q),
        .data_i   (tx_byte_q),
        .txd_o    (txd_o),
        .busy_o   (tx_busy)
    );

    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_rx (
        .clk_i    (clk_i),
        .locked_i (locked_i),
        .rxd_i    (rxd_i),
        .valid_o  (rx_valid),
        .data_o   (rx_data)
    );

endmodule

`default_nettype wire

//--- logic/sram_bank.sv
`timescale 1ns/1ps
`default_nettype none

module sram_bank import mem_pkg::*; #(
    parameter int MEM_AW = 10
) (
    input  wire logic              clk_i,
    input  wire logic              en_i,
    input  wire logic              we_i,
    input  wire be_t               be_i,
    input  wire logic [MEM_AW-1:0] addr_i,
    input  wire word_t             wdata_i,
    output word_t                  rdata_o
);

    localparam int DEPTH = 2 ** MEM_AW;

    word_t mem [DEPTH];

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (en_i) begin
            if (we_i) begin
                for (int b = 0; b < 4; b++) begin
                    if (be_i[b])
                        mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];   // lane b
                end
            end
            rdata_o <= mem[addr_i];   // old data on a write cycle
        end
    end

endmodule

`default_nettype wire

//--- logic/bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter import mem_pkg::*; #(
    parameter int MEM_AW = 10
) (
    input  wire logic              clk_i,
    input  wire logic              locked_i,
    input  wire logic              ifu_req_i,
    input  wire word_t             ifu_addr_i,
    input  wire logic              lsu_req_i,
    input  wire logic              lsu_we_i,
    input  wire be_t               lsu_be_i,
    input  wire word_t             lsu_addr_i,
    input  wire word_t             lsu_wdata_i,
    input  wire word_t             base_rdata_i,
    input  wire word_t             ext_rdata_i,
    input  wire logic              tx_ready_i,
    input  wire logic              rx_avail_i,
    input  wire byte_t             rx_byte_i,
    output logic                   ifu_resp_o,
    output word_t                  ifu_rdata_o,
    output logic                   lsu_resp_o,
    output word_t                  lsu_rdata_o,
    output logic                   base_en_o,
    output logic                   base_we_o,
    output be_t                    base_be_o,
    output logic [MEM_AW-1:0]      base_addr_o,
    output word_t                  base_wdata_o,
    output logic                   ext_en_o,
    output logic                   ext_we_o,
    output be_t                    ext_be_o,
    output logic [MEM_AW-1:0]      ext_addr_o,
    output word_t                  ext_wdata_o,
    output logic                   uart_rd_o,
    output logic                   uart_wr_o,
    output byte_t                  uart_wbyte_o
);

    bus_target_e lsu_tgt;
    bus_target_e lsu_tgt_q;   // target of the served load/store
    logic        lsu_we_q;
    logic        lsu_base;
    logic        ifu_grant;
    word_t       uart_word;
    word_t       uart_rdata_q;

    always_comb begin
        if (lsu_addr_i[31:REGION_LSB] == BASE_RAM_BASE[31:REGION_LSB])
            lsu_tgt = tgt_base;
        else if (lsu_addr_i[31:REGION_LSB] == EXT_RAM_BASE[31:REGION_LSB])
            lsu_tgt = tgt_ext;
        else if (lsu_addr_i == UART_DATA_ADDR)
            lsu_tgt = tgt_uart_data;
        else if (lsu_addr_i == UART_STAT_ADDR)
            lsu_tgt = tgt_uart_stat;
        else
            lsu_tgt = tgt_none;
    end

    // load/store wins the base ram, fetch retries
    assign lsu_base  = lsu_req_i && (lsu_tgt == tgt_base);
    assign ifu_grant = ifu_req_i && !lsu_base;

    assign base_en_o    = lsu_base || ifu_grant;
    assign base_we_o    = lsu_base && lsu_we_i;
    assign base_be_o    = lsu_be_i;
    assign base_addr_o  = lsu_base ? lsu_addr_i[MEM_AW+1:2] : ifu_addr_i[MEM_AW+1:2];
    assign base_wdata_o = lsu_wdata_i;

    assign ext_en_o    = lsu_req_i && (lsu_tgt == tgt_ext);
    assign ext_we_o    = ext_en_o && lsu_we_i;
    assign ext_be_o    = lsu_be_i;
    assign ext_addr_o  = lsu_addr_i[MEM_AW+1:2];
    assign ext_wdata_o = lsu_wdata_i;

    assign uart_rd_o    = lsu_req_i && !lsu_we_i && (lsu_tgt == tgt_uart_data);
    assign uart_wr_o    = lsu_req_i && lsu_we_i && (lsu_tgt == tgt_uart_data);
    assign uart_wbyte_o = lsu_wdata_i[7:0];

    // status: bit 1 rx available, bit 0 tx ready
    assign uart_word = (lsu_tgt == tgt_uart_data) ? {24'd0, rx_byte_i}
                                                  : {30'd0, rx_avail_i, tx_ready_i};

    always_ff @(posedge clk_i or negedge locked_i) begin
        if (!locked_i) begin
            ifu_resp_o <= 1'b0;
            lsu_resp_o <= 1'b0;
            lsu_tgt_q  <= tgt_none;
            lsu_we_q   <= 1'b0;
        end else begin
            ifu_resp_o <= ifu_grant;
            lsu_resp_o <= lsu_req_i;
            lsu_tgt_q  <= lsu_tgt;
            lsu_we_q   <= lsu_we_i;
        end
    end

    always_ff @(posedge clk_i) begin
        uart_rdata_q <= uart_word;   // sampled at the serving edge
    end

    assign ifu_rdata_o = base_rdata_i;

    always_comb begin
        case (lsu_tgt_q)
            tgt_base:      lsu_rdata_o = base_rdata_i;
            tgt_ext:       lsu_rdata_o = ext_rdata_i;
            tgt_uart_data,
            tgt_uart_stat: lsu_rdata_o = uart_rdata_q;
            default:       lsu_rdata_o = '0;
        endcase
        if (lsu_we_q)
            lsu_rdata_o = '0;   // stores answer with zero
    end

    // both ports answered together only if the load/store left base ram alone
    a_one_base_grant: assert property (@(posedge clk_i) disable iff (!locked_i)
        (ifu_resp_o && lsu_resp_o) |-> (lsu_tgt_q != tgt_base));

    a_ifu_resp_has_req: assert property (@(posedge clk_i) disable iff (!locked_i)
        ifu_resp_o |-> $past(ifu_req_i));

    a_lsu_resp_has_req: assert property (@(posedge clk_i) disable iff (!locked_i)
        lsu_resp_o |-> $past(lsu_req_i));

endmodule

`default_nettype wire

//--- logic/mem_system.sv
`timescale 1ns/1ps
`default_nettype none

module mem_system import mem_pkg::*; #(
    parameter int MEM_AW       = 10,
    parameter int CLKS_PER_BIT = 16
) (
    input  wire logic  clk_i,
    input  wire logic  locked_i,
    input  wire logic  ifu_req_i,
    input  wire word_t ifu_addr_i,
    output word_t      ifu_rdata_o,
    output logic       ifu_resp_o,
    input  wire logic  lsu_req_i,
    input  wire logic  lsu_we_i,
    input  wire be_t   lsu_be_i,
    input  wire word_t lsu_addr_i,
    input  wire word_t lsu_wdata_i,
    output word_t      lsu_rdata_o,
    output logic       lsu_resp_o,
    input  wire logic  rxd_i,
    output logic       txd_o
);

    logic              base_en;
    logic              base_we;
    be_t               base_be;
    logic [MEM_AW-1:0] base_addr;
    word_t             base_wdata;
    word_t             base_rdata;

    logic              ext_en;
    logic              ext_we;
    be_t               ext_be;
    logic [MEM_AW-1:0] ext_addr;
    word_t             ext_wdata;
    word_t             ext_rdata;

    logic              uart_rd;
    logic              uart_wr;
    byte_t             uart_wbyte;
    logic              tx_ready;
    logic              rx_avail;
    byte_t             rx_byte;

    bus_arbiter #(.MEM_AW(MEM_AW)) u_arbiter (
        .clk_i        (clk_i),
        .locked_i     (locked_i),
        .ifu_req_i    (ifu_req_i),
        .ifu_addr_i   (ifu_addr_i),
        .lsu_req_i    (lsu_req_i),
        .lsu_we_i     (lsu_we_i),
        .lsu_be_i     (lsu_be_i),
        .lsu_addr_i   (lsu_addr_i),
        .lsu_wdata_i  (lsu_wdata_i),
        .base_rdata_i (base_rdata),
        .ext_rdata_i  (ext_rdata),
        .tx_ready_i   (tx_ready),
        .rx_avail_i   (rx_avail),
        .rx_byte_i    (rx_byte),
        .ifu_resp_o   (ifu_resp_o),
        .ifu_rdata_o  (ifu_rdata_o),
        .lsu_resp_o   (lsu_resp_o),
        .lsu_rdata_o  (lsu_rdata_o),
        .base_en_o    (base_en),
        .base_we_o    (base_we),
        .base_be_o    (base_be),
        .base_addr_o  (base_addr),
        .base_wdata_o (base_wdata),
        .ext_en_o     (ext_en),
        .ext_we_o     (ext_we),
        .ext_be_o     (ext_be),
        .ext_addr_o   (ext_addr),
        .ext_wdata_o  (ext_wdata),
        .uart_rd_o    (uart_rd),
        .uart_wr_o    (uart_wr),
        .uart_wbyte_o (uart_wbyte)
    );

    // shared by fetch and load/store
    sram_bank #(.MEM_AW(MEM_AW)) u_base_ram (
        .clk_i   (clk_i),
        .en_i    (base_en),
        .we_i    (base_we),
        .be_i    (base_be),
        .addr_i  (base_addr),
        .wdata_i (base_wdata),
        .rdata_o (base_rdata)
    );

    sram_bank #(.MEM_AW(MEM_AW)) u_ext_ram (
        .clk_i   (clk_i),
        .en_i    (ext_en),
        .we_i    (ext_we),
        .be_i    (ext_be),
        .addr_i  (ext_addr),
        .wdata_i (ext_wdata),
        .rdata_o (ext_rdata)
    );

    serial_port #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_serial (
        .clk_i      (clk_i),
        .locked_i   (locked_i),
        .rd_i       (uart_rd),
        .wr_i       (uart_wr),
        .wbyte_i    (uart_wbyte),
        .rxd_i      (rxd_i),
        .txd_o      (txd_o),
        .tx_ready_o (tx_ready),
        .rx_avail_o (rx_avail),
        .rx_byte_o  (rx_byte)
    );

endmodule

`default_nettype wire

//--- tests/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// test names from the trace, up to 24 characters
typedef logic [8*24-1:0] name_t;

int word_errs  = 0;
int bit_errs   = 0;
int byte_errs  = 0;
int event_errs = 0;   // missing resp, bad frames

task automatic check_word(input name_t name, input word_t exp, input word_t act);
    if (act !== exp) begin
        word_errs++;
        $display("Fail %0s: expected %h, actual %h", name, exp, act);
    end
endtask

task automatic check_bit(input name_t name, input logic exp, input logic act);
    if (act !== exp) begin
        bit_errs++;
        $display("Fail %0s: expected %b, actual %b", name, exp, act);
    end
endtask

task automatic check_byte(input name_t name, input byte_t exp, input byte_t act);
    if (act !== exp) begin
        byte_errs++;
        $display("Fail %0s: expected %h, actual %h", name, exp, act);
    end
endtask

task automatic note_failure(input string what);
    event_errs++;
    $display("Error: %0s", what);
endtask

function automatic int total_errors();
    return word_errs + bit_errs + byte_errs + event_errs;
endfunction

`endif

//--- tests/mem_system_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_system_tb import mem_pkg::*; ();

    `include "tb_checks.svh"

    localparam int CLKS_PER_BIT = 16;
    localparam int MAX_OPS      = 64;

    logic  clk_i = 1'b0;
    logic  locked_i;
    logic  ifu_req_i;
    word_t ifu_addr_i;
    logic  lsu_req_i;
    logic  lsu_we_i;
    be_t   lsu_be_i;
    word_t lsu_addr_i;
    word_t lsu_wdata_i;
    logic  rxd_i;
    word_t ifu_rdata_o;
    logic  ifu_resp_o;
    word_t lsu_rdata_o;
    logic  lsu_resp_o;
    logic  txd_o;

    // trace contents
    logic [7:0] t_op   [MAX_OPS];
    name_t      t_name [MAX_OPS];
    word_t      t_addr [MAX_OPS];
    word_t      t_data [MAX_OPS];
    be_t        t_be   [MAX_OPS];
    word_t      t_exp  [MAX_OPS];
    int         n_ops = 0;

    int    cycles      = 0;
    int    cycle_limit = 0;   // 0 until the trace is loaded
    logic  got_ifu_resp;
    logic  got_lsu_resp;
    word_t got_ifu_rdata;
    word_t got_lsu_rdata;
    byte_t tx_bytes [$];      // frames decoded from txd

    // fetch held back by a P line, issued with the next load/store
    logic  pend_fetch = 1'b0;
    logic  pend_resp;
    name_t pend_name;
    word_t pend_addr;
    word_t pend_exp;

    always #4 clk_i = ~clk_i;

    mem_system #(.MEM_AW(10), .CLKS_PER_BIT(CLKS_PER_BIT)) UUT (
        .clk_i       (clk_i),
        .locked_i    (locked_i),
        .ifu_req_i   (ifu_req_i),
        .ifu_addr_i  (ifu_addr_i),
        .ifu_rdata_o (ifu_rdata_o),
        .ifu_resp_o  (ifu_resp_o),
        .lsu_req_i   (lsu_req_i),
        .lsu_we_i    (lsu_we_i),
        .lsu_be_i    (lsu_be_i),
        .lsu_addr_i  (lsu_addr_i),
        .lsu_wdata_i (lsu_wdata_i),
        .lsu_rdata_o (lsu_rdata_o),
        .lsu_resp_o  (lsu_resp_o),
        .rxd_i       (rxd_i),
        .txd_o       (txd_o)
    );

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("Error: run passed %0d cycles without finishing", cycle_limit);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic load_trace();
        int             fd;
        int             n;
        logic [8*128-1:0] line;
        logic [8*8-1:0] op_tok;
        name_t          nm;
        word_t          a;
        word_t          d;
        be_t            b;
        word_t          e;
        fd = $fopen("tests/mem_trace.txt", "r");
        if (fd == 0) begin
            note_failure("cannot open tests/mem_trace.txt");
            return;
        end
        line = '0;
        while ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "%s %s %h %h %h %h", op_tok, nm, a, d, b, e);
            if (n == 6 && n_ops < MAX_OPS) begin   // comment and blank lines fall out here
                t_op[n_ops]   = op_tok[7:0];
                t_name[n_ops] = nm;
                t_addr[n_ops] = a;
                t_data[n_ops] = d;
                t_be[n_ops]   = b;
                t_exp[n_ops]  = e;
                n_ops++;
            end
            line = '0;
        end
        $fclose(fd);
    endtask

    // called on a falling edge, returns on the next one with the resp sampled
    task automatic bus_cycle(input logic f_req, input word_t f_addr, input logic l_req,
                             input logic l_we, input be_t l_be, input word_t l_addr,
                             input word_t l_wdata);
        ifu_req_i   = f_req;
        ifu_addr_i  = f_addr;
        lsu_req_i   = l_req;
        lsu_we_i    = l_we;
        lsu_be_i    = l_be;
        lsu_addr_i  = l_addr;
        lsu_wdata_i = l_wdata;
        @(negedge clk_i);
        ifu_req_i     = 1'b0;
        lsu_req_i     = 1'b0;
        got_ifu_resp  = ifu_resp_o;
        got_ifu_rdata = ifu_rdata_o;
        got_lsu_resp  = lsu_resp_o;
        got_lsu_rdata = lsu_rdata_o;
    endtask

    task automatic require_resp(input name_t name, input string port, input logic seen);
        if (seen !== 1'b1)
            note_failure($sformatf("%0s: no response on the %0s port", name, port));
    endtask

    task automatic send_frame(input byte_t value);
        rxd_i = 1'b0;   // start bit
        repeat (CLKS_PER_BIT) @(negedge clk_i);
        for (int i = 0; i < 8; i++) begin
            rxd_i = value[i];
            repeat (CLKS_PER_BIT) @(negedge clk_i);
        end
        rxd_i = 1'b1;
        repeat (CLKS_PER_BIT) @(negedge clk_i);
    endtask

    // poll the status word for bit 1, two frame times at most
    task automatic wait_rx_flag(input name_t name);
        int waited;
        waited        = 0;
        got_lsu_rdata = '0;
        while (!got_lsu_rdata[1] && waited < 20 * CLKS_PER_BIT) begin
            bus_cycle(1'b0, '0, 1'b1, 1'b0, '0, UART_STAT_ADDR, '0);
            waited++;
        end
        if (!got_lsu_rdata[1])
            note_failure($sformatf("%0s: receive flag not set within two frames", name));
    endtask

    task automatic run_op(input int i);
        case (t_op[i])
            "F": begin
                bus_cycle(1'b1, t_addr[i], 1'b0, 1'b0, '0, '0, '0);
                require_resp(t_name[i], "fetch", got_ifu_resp);
                check_word(t_name[i], t_exp[i], got_ifu_rdata);
            end
            "L", "S": begin
                bus_cycle(pend_fetch, pend_addr, 1'b1, t_op[i] == "S", t_be[i],
                          t_addr[i], t_data[i]);
                require_resp(t_name[i], "load/store", got_lsu_resp);
                check_word(t_name[i], t_exp[i], got_lsu_rdata);
                if (pend_fetch && pend_resp) begin
                    require_resp(pend_name, "fetch", got_ifu_resp);
                    check_word(pend_name, pend_exp, got_ifu_rdata);
                end else if (pend_fetch) begin
                    check_bit(pend_name, 1'b0, got_ifu_resp);   // lost to the load/store
                end
                pend_fetch = 1'b0;
            end
            "P": begin
                pend_fetch = 1'b1;
                pend_resp  = t_be[i][0];
                pend_name  = t_name[i];
                pend_addr  = t_addr[i];
                pend_exp   = t_exp[i];
            end
            "R": begin
                send_frame(t_data[i][7:0]);
                wait_rx_flag(t_name[i]);
            end
            "T": begin
                while (tx_bytes.size() == 0)
                    @(negedge clk_i);
                check_byte(t_name[i], t_exp[i][7:0], tx_bytes.pop_front());
            end
            default: note_failure($sformatf("unknown op in trace line %0d", i));
        endcase
    endtask

    // txd decoder, samples near the middle of each bit
    initial begin : tx_monitor
        byte_t frame;
        @(posedge locked_i);
        forever begin
            @(negedge txd_o);
            repeat (CLKS_PER_BIT / 2) @(negedge clk_i);
            if (txd_o !== 1'b0) begin
                note_failure("start bit on txd ended early");
            end else begin
                for (int i = 0; i < 8; i++) begin
                    repeat (CLKS_PER_BIT) @(negedge clk_i);
                    frame[i] = txd_o;
                end
                repeat (CLKS_PER_BIT) @(negedge clk_i);
                if (txd_o !== 1'b1)
                    note_failure("stop bit on txd missing");
                else
                    tx_bytes.push_back(frame);
            end
        end
    end

    initial begin
        locked_i    = 1'b0;
        ifu_req_i   = 1'b0;
        ifu_addr_i  = '0;
        lsu_req_i   = 1'b0;
        lsu_we_i    = 1'b0;
        lsu_be_i    = '0;
        lsu_addr_i  = '0;
        lsu_wdata_i = '0;
        rxd_i       = 1'b1;   // serial line idles high
        load_trace();
        if (n_ops == 0)
            note_failure("trace holds no operations");
        cycle_limit = n_ops * (12 * CLKS_PER_BIT + 8) + 100;
        repeat (4) @(negedge clk_i);
        locked_i = 1'b1;
        @(negedge clk_i);
        for (int i = 0; i < n_ops; i++)
            run_op(i);
        repeat (12 * CLKS_PER_BIT) @(negedge clk_i);   // room for a stray frame
        if (tx_bytes.size() != 0)
            note_failure("unexpected frame on txd");
        $display("errors: word %0d, bit %0d, byte %0d, other %0d",
                 word_errs, bit_errs, byte_errs, event_errs);
        if (total_errors() == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/mem_trace.txt
# op name addr data be expected, numbers in hex
# P: fetch sent with the next load, be bit 0 = fetch resp expected
S ext_st_full      80400010 11223344 f 00000000
L ext_ld_full      80400010 00000000 0 11223344
S ext_st_lo        80400014 aabbccdd 3 00000000
L ext_ld_lo        80400014 00000000 0 0000ccdd
S ext_st_hi        80400014 55667788 c 00000000
L ext_ld_hi        80400014 00000000 0 5566ccdd
S ext_st_b1        80400018 12345678 2 00000000
L ext_ld_b1        80400018 00000000 0 00005600
L ext_ld_zero      8040001c 00000000 0 00000000
S base_st_a        80000100 cafef00d f 00000000
S base_st_b        80000104 0badbeef f 00000000
S base_st_c        80000200 13579bdf f 00000000
F fetch_a          80000100 00000000 0 cafef00d
F fetch_b          80000104 00000000 0 0badbeef
F fetch_alias      80001100 00000000 0 cafef00d
P coll_fetch       80000104 00000000 0 00000000
L coll_load        80000200 00000000 0 13579bdf
F coll_retry       80000104 00000000 0 0badbeef
P par_fetch        80000100 00000000 1 cafef00d
L par_load         80400010 00000000 0 11223344
L uart_stat_idle   bfd003fc 00000000 0 00000001
S uart_tx_store    bfd003f8 000000a5 1 00000000
L uart_stat_busy   bfd003fc 00000000 0 00000000
S uart_tx_drop     bfd003f8 000000ff 1 00000000
T uart_tx_frame    00000000 00000000 0 000000a5
R uart_rx_drive    00000000 0000005a 0 00000000
L uart_rx_data     bfd003f8 00000000 0 0000005a
L uart_rx_stat     bfd003fc 00000000 0 00000001
L unmapped_load    90000000 00000000 0 00000000
S unmapped_store   90000000 ffffffff f 00000000

//--- sim.f
+incdir+tests
logic/mem_pkg.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/serial_port.sv
logic/sram_bank.sv
logic/bus_arbiter.sv
logic/mem_system.sv
tests/mem_system_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the memory system testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module mem_system_tb -f sim.f -Mdir obj_dir -o mem_system_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/mem_system_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: FAIL" "$LOG"; then
    exit 1
fi
exit 0
